// File: hdl/rv_pkg.sv
// **********************************************************************
// shared widths, opcodes and types for the single-cycle rv64 core
// only lui, auipc, addi, add, sub, jal and ebreak are encoded here
// **********************************************************************
`default_nettype none

package rv_pkg;

  // datapath widths
  localparam int xlen         = 64;
  localparam int inst_width   = 32;
  localparam int reg_id_width = 5;

  // instruction memory geometry, word indexed
  localparam int imem_depth      = 256;
  localparam int imem_addr_width = 8;

  // pc after reset, also the base of the memory window
  localparam logic [xlen-1:0] pc_rst = 64'h0000_0000_8000_0000;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_op_imm = 7'b0010011;
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_system = 7'b1110011;

  // add and addi share funct3
  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [6:0] f7_add = 7'b0000000;
  localparam logic [6:0] f7_sub = 7'b0100000;

  // whole word, no free fields
  localparam logic [inst_width-1:0] ebreak_word = 32'h0010_0073;

  // one word, four format views plus raw bits
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
    // j immediate bits are scrambled in the word
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
    logic [inst_width-1:0] raw;
  } inst_t;

  // run control states
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_run     = 2'd1,
    st_halted  = 2'd2,
    st_trapped = 2'd3
  } run_state_t;

endpackage

`default_nettype wire

// File: hdl/inst_mem.sv
// **********************************************************************
// instruction memory, host write port and registered fetch, no reset
// host must only write while the core is idle, nothing checks this
// **********************************************************************
`timescale 1ns/10ps
`default_nettype none

module inst_mem (
  input  logic                               clk,
  input  logic                               load_en,
  input  logic [rv_pkg::imem_addr_width-1:0] load_addr,
  input  logic [rv_pkg::inst_width-1:0]      load_data,
  input  logic [rv_pkg::imem_addr_width-1:0] fetch_addr,
  output logic [rv_pkg::inst_width-1:0]      inst
);

  // word array, contents undefined until loaded
  logic [rv_pkg::inst_width-1:0] mem [rv_pkg::imem_depth];

  // host load port
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // fetch at next pc index so inst lines up with current pc
  // same-address read during a write returns the old word
  always_ff @(posedge clk) begin
    inst <= mem[fetch_addr];
  end

endmodule

`default_nettype wire

// File: hdl/inst_decoder.sv
// **********************************************************************
// decodes lui, auipc, addi, add, sub, jal and ebreak only
// every other word raises illegal and never writes a register
// **********************************************************************
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
  input  rv_pkg::inst_t                    inst,
  output logic [rv_pkg::reg_id_width-1:0]  rd,
  output logic [rv_pkg::reg_id_width-1:0]  rs1,
  output logic [rv_pkg::reg_id_width-1:0]  rs2,
  output logic [rv_pkg::xlen-1:0]          imm,
  output logic                             writes_rd,
  output logic                             use_imm,
  output logic                             use_pc,
  output logic                             is_sub,
  output logic                             is_lui,
  output logic                             is_jal,
  output logic                             is_ebreak,
  output logic                             illegal
);

  // register ids sit at the same bits in every format
  assign rd  = inst.r_fmt.rd;
  assign rs1 = inst.r_fmt.rs1;
  assign rs2 = inst.r_fmt.rs2;

  // immediate by format
  always_comb begin
    case (inst.r_fmt.opcode)
      rv_pkg::op_lui, rv_pkg::op_auipc: begin
        imm = {{(rv_pkg::xlen-32){inst.u_fmt.imm[19]}}, inst.u_fmt.imm, 12'b0};
      end
      rv_pkg::op_jal: begin
        imm = {{(rv_pkg::xlen-21){inst.j_fmt.imm20}}, inst.j_fmt.imm20,
               inst.j_fmt.imm19_12, inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};
      end
      // i format, don't care for r type
      default: begin
        imm = {{(rv_pkg::xlen-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
      end
    endcase
  end

  // control flags, exact match on the legal encodings
  always_comb begin
    writes_rd = 1'b0;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    is_sub    = 1'b0;
    is_lui    = 1'b0;
    is_jal    = 1'b0;
    is_ebreak = 1'b0;
    illegal   = 1'b0;
    case (inst.r_fmt.opcode)
      rv_pkg::op_lui: begin
        writes_rd = 1'b1;
        is_lui    = 1'b1;
      end
      // pc plus upper immediate
      rv_pkg::op_auipc: begin
        writes_rd = 1'b1;
        use_imm   = 1'b1;
        use_pc    = 1'b1;
      end
      rv_pkg::op_op_imm: begin
        if (inst.i_fmt.funct3 == rv_pkg::f3_add) begin
          writes_rd = 1'b1;
          use_imm   = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      rv_pkg::op_op: begin
        if (inst.r_fmt.funct3 != rv_pkg::f3_add) begin
          illegal = 1'b1;
        end else if (inst.r_fmt.funct7 == rv_pkg::f7_add) begin
          writes_rd = 1'b1;
        end else if (inst.r_fmt.funct7 == rv_pkg::f7_sub) begin
          writes_rd = 1'b1;
          is_sub    = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      // link value comes from the exec unit
      rv_pkg::op_jal: begin
        writes_rd = 1'b1;
        is_jal    = 1'b1;
      end
      // ecall, csr ops and the rest of system trap
      rv_pkg::op_system: begin
        if (inst.raw == rv_pkg::ebreak_word) begin
          is_ebreak = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
// **********************************************************************
// 32 x 64 register file, x0 reads zero and ignores writes
// registers are not reset, contents undefined until written
// **********************************************************************
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  logic                            clk,
  input  logic                            wen,
  input  logic [rv_pkg::reg_id_width-1:0] rd,
  input  logic [rv_pkg::reg_id_width-1:0] rs1,
  input  logic [rv_pkg::reg_id_width-1:0] rs2,
  input  logic [rv_pkg::xlen-1:0]         wdata,
  output logic [rv_pkg::xlen-1:0]         rdata_1,
  output logic [rv_pkg::xlen-1:0]         rdata_2
);

  // entry 0 exists but is never written or read
  logic [rv_pkg::xlen-1:0] regs [2**rv_pkg::reg_id_width];

  // write back on the retire edge
  always_ff @(posedge clk) begin
    if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // combinational reads, no bypass
  assign rdata_1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata_2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
// **********************************************************************
// operand muxes, adder-subtractor and write-back select, combinational
// **********************************************************************
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
  input  logic [rv_pkg::xlen-1:0] current_pc,
  input  logic [rv_pkg::xlen-1:0] rdata_1,
  input  logic [rv_pkg::xlen-1:0] rdata_2,
  input  logic [rv_pkg::xlen-1:0] imm,
  input  logic                    use_imm,
  input  logic                    use_pc,
  input  logic                    is_sub,
  input  logic                    is_lui,
  input  logic                    is_jal,
  output logic [rv_pkg::xlen-1:0] wb_data
);

  logic [rv_pkg::xlen-1:0] operand_1;
  logic [rv_pkg::xlen-1:0] operand_2;
  logic [rv_pkg::xlen-1:0] alu_result;
  logic [rv_pkg::xlen-1:0] link_addr;

  // pc for auipc, rs1 otherwise
  assign operand_1 = use_pc ? current_pc : rdata_1;
  // immediate for addi and auipc
  assign operand_2 = use_imm ? imm : rdata_2;

  // single adder, sub only for the r type sub
  assign alu_result = is_sub ? (operand_1 - operand_2) : (operand_1 + operand_2);

  // return address for jal
  assign link_addr = current_pc + rv_pkg::xlen'(4);

  // write-back choice
  always_comb begin
    if (is_jal) begin
      wb_data = link_addr;
    end else if (is_lui) begin
      // upper immediate already shifted and sign extended
      wb_data = imm;
    end else begin
      wb_data = alu_result;
    end
  end

endmodule

`default_nettype wire

// File: hdl/pc_counter.sv
// **********************************************************************
// program counter, steps by 4 or jumps for jal, holds when not running
// running must already be qualified by retire
// **********************************************************************
`timescale 1ns/10ps
`default_nettype none

module pc_counter (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    running,
  input  logic                    is_jal,
  input  logic [rv_pkg::xlen-1:0] imm,
  output logic [rv_pkg::xlen-1:0] current_pc,
  output logic [rv_pkg::xlen-1:0] next_pc
);

  // next pc, also drives the fetch index
  always_comb begin
    if (running && is_jal) begin
      next_pc = current_pc + imm;
    end else if (running) begin
      next_pc = current_pc + rv_pkg::xlen'(4);
    end else begin
      // idle, halted, trapped
      next_pc = current_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      current_pc <= rv_pkg::pc_rst;
    end else begin
      current_pc <= next_pc;
    end
  end

  // jal offsets from the program keep the word alignment
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (reset) current_pc[1:0] == 2'b00
  ) else $error("pc lost 4-byte alignment");

endmodule

`default_nettype wire

// File: hdl/run_control.sv
// **********************************************************************
// run control fsm, idle to run on start, halted or trapped until reset
// retire is combinational from state and the decode flags
// **********************************************************************
`timescale 1ns/10ps
`default_nettype none

module run_control (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  logic               is_ebreak,
  input  logic               illegal,
  output rv_pkg::run_state_t state,
  output logic               retire,
  output logic               halted,
  output logic               trapped
);

  rv_pkg::run_state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      rv_pkg::st_idle: begin
        if (start) begin
          state_next = rv_pkg::st_run;
        end
      end
      rv_pkg::st_run: begin
        // ebreak checked first, they cannot both be set
        if (is_ebreak) begin
          state_next = rv_pkg::st_halted;
        end else if (illegal) begin
          state_next = rv_pkg::st_trapped;
        end
      end
      // halted and trapped only leave through reset
      default: begin
        state_next = state;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rv_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  // one instruction retires per run cycle
  assign retire = (state == rv_pkg::st_run) && !is_ebreak && !illegal;

  // sticky stop flags, set on the edge that leaves run
  always_ff @(posedge clk) begin
    if (reset) begin
      halted  <= 1'b0;
      trapped <= 1'b0;
    end else if (state == rv_pkg::st_run) begin
      if (is_ebreak) begin
        halted <= 1'b1;
      end else if (illegal) begin
        trapped <= 1'b1;
      end
    end
  end

  a_stop_exclusive : assert property (
    @(posedge clk) disable iff (reset) !(halted && trapped)
  ) else $error("halted and trapped both high");

endmodule

`default_nettype wire

// File: hdl/rv_core_top.sv
// **********************************************************************
// single-cycle rv64 core, host loads memory in idle, then pulses start
// fetch index wraps modulo the memory depth above pc_rst
// **********************************************************************
`timescale 1ns/10ps
`default_nettype none

module rv_core_top (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               load_en,
  input  logic [rv_pkg::imem_addr_width-1:0] load_addr,
  input  logic [rv_pkg::inst_width-1:0]      load_data,
  input  logic                               start,
  output logic                               retire,
  output logic [rv_pkg::xlen-1:0]            retire_pc,
  output logic                               wb_en,
  output logic [rv_pkg::reg_id_width-1:0]    wb_rd,
  output logic [rv_pkg::xlen-1:0]            wb_data,
  output rv_pkg::run_state_t                 state,
  output logic                               halted,
  output logic                               trapped
);

  rv_pkg::inst_t                      inst;
  logic [rv_pkg::xlen-1:0]            current_pc;
  logic [rv_pkg::xlen-1:0]            next_pc;
  logic [rv_pkg::xlen-1:0]            fetch_offset;
  logic [rv_pkg::imem_addr_width-1:0] fetch_addr;

  logic [rv_pkg::reg_id_width-1:0]    rd;
  logic [rv_pkg::reg_id_width-1:0]    rs1;
  logic [rv_pkg::reg_id_width-1:0]    rs2;
  logic [rv_pkg::xlen-1:0]            imm;
  logic [rv_pkg::xlen-1:0]            rdata_1;
  logic [rv_pkg::xlen-1:0]            rdata_2;
  logic writes_rd;
  logic use_imm;
  logic use_pc;
  logic is_sub;
  logic is_lui;
  logic is_jal;
  logic is_ebreak;
  logic illegal;

  // word index of next pc relative to pc_rst
  assign fetch_offset = next_pc - rv_pkg::pc_rst;
  assign fetch_addr   = fetch_offset[rv_pkg::imem_addr_width+1:2];

  inst_mem u_inst_mem (
    .clk        (clk),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .fetch_addr (fetch_addr),
    .inst       (inst)
  );

  inst_decoder u_inst_decoder (
    .inst      (inst),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .imm       (imm),
    .writes_rd (writes_rd),
    .use_imm   (use_imm),
    .use_pc    (use_pc),
    .is_sub    (is_sub),
    .is_lui    (is_lui),
    .is_jal    (is_jal),
    .is_ebreak (is_ebreak),
    .illegal   (illegal)
  );

  // write lands on the retire edge
  reg_file u_reg_file (
    .clk     (clk),
    .wen     (wb_en),
    .rd      (rd),
    .rs1     (rs1),
    .rs2     (rs2),
    .wdata   (wb_data),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2)
  );

  exec_unit u_exec_unit (
    .current_pc (current_pc),
    .rdata_1    (rdata_1),
    .rdata_2    (rdata_2),
    .imm        (imm),
    .use_imm    (use_imm),
    .use_pc     (use_pc),
    .is_sub     (is_sub),
    .is_lui     (is_lui),
    .is_jal     (is_jal),
    .wb_data    (wb_data)
  );

  // pc only moves on a retiring instruction
  pc_counter u_pc_counter (
    .clk        (clk),
    .reset      (reset),
    .running    (retire),
    .is_jal     (is_jal),
    .imm        (imm),
    .current_pc (current_pc),
    .next_pc    (next_pc)
  );

  run_control u_run_control (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .is_ebreak (is_ebreak),
    .illegal   (illegal),
    .state     (state),
    .retire    (retire),
    .halted    (halted),
    .trapped   (trapped)
  );

  assign retire_pc = current_pc;
  assign wb_rd     = rd;
  // x0 writes still show wb_en, the file drops them
  assign wb_en     = retire && writes_rd;

endmodule

`default_nettype wire

// File: tb/rv_iss.svh
// **********************************************************************
// reference model and program generator, included inside the testbench
// model registers persist across programs like the unreset register file
// **********************************************************************
`ifndef RV_ISS_SVH
`define RV_ISS_SVH

logic [31:0]                     rng_state;
logic [31:0]                     prog [$];
logic [rv_pkg::xlen-1:0]         model_regs [32];
// registers the executed path has written, x0 always counts
bit                              reg_written [32];
logic [rv_pkg::xlen-1:0]         exp_pc [$];
logic [rv_pkg::reg_id_width-1:0] exp_rd [$];
logic [rv_pkg::xlen-1:0]         exp_data [$];
rv_pkg::run_state_t              exp_final;
logic [rv_pkg::xlen-1:0]         exp_stop_pc;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic logic [31:0] rand_word();
  rng_state = xorshift32(rng_state);
  return rng_state;
endfunction

// encoders straight from the isa field layout
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [4:0] rd);
  return {f7, rs2, rs1, 3'b000, rd, rv_pkg::op_op};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [4:0] rd);
  return {imm, rs1, 3'b000, rd, rv_pkg::op_op_imm};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opcode);
  return {imm, rd, opcode};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::op_jal};
endfunction

// source register that already holds a known value
function automatic logic [4:0] pick_src();
  logic [31:0] r;
  int          k;
  for (k = 0; k < 8; k++) begin
    r = rand_word();
    if (reg_written[r[4:0]]) begin
      return r[4:0];
    end
  end
  return 5'd0;
endfunction

// load, branch, mul or ecall
function automatic logic [31:0] illegal_word();
  logic [31:0] r;
  r = rand_word();
  case (r[1:0])
    2'd0:    return {r[31:7], 7'b0000011};
    2'd1:    return {r[31:7], 7'b1100011};
    2'd2:    return {7'b0000001, r[24:15], 3'b000, r[11:7], rv_pkg::op_op};
    default: return 32'h0000_0073;
  endcase
endfunction

// n_exec retiring instructions on the executed path, then the stop word
task automatic build_program(input int n_exec, input bit end_illegal);
  int          done_cnt;
  int          kind;
  int          skip;
  int          s;
  logic [31:0] r;
  logic [4:0]  rd;
  prog.delete();
  done_cnt = 0;
  while (done_cnt < n_exec) begin
    kind = rand_word() % 6;
    r    = rand_word();
    rd   = r[4:0];
    case (kind)
      0: prog.push_back(enc_r(rv_pkg::f7_add, pick_src(), pick_src(), rd));
      1: prog.push_back(enc_r(rv_pkg::f7_sub, pick_src(), pick_src(), rd));
      2: prog.push_back(enc_i(r[31:20], pick_src(), rd));
      3: prog.push_back(enc_u(r[31:12], rd, rv_pkg::op_lui));
      4: prog.push_back(enc_u(r[31:12], rd, rv_pkg::op_auipc));
      default: begin
        // forward jump over 0 to 3 junk words
        skip = r[9:8];
        prog.push_back(enc_j(21'((skip + 1) * 4), rd));
        for (s = 0; s < skip; s++) begin
          prog.push_back(rand_word());
        end
      end
    endcase
    reg_written[rd] = 1'b1;
    done_cnt++;
  end
  if (end_illegal) begin
    prog.push_back(illegal_word());
  end else begin
    prog.push_back(rv_pkg::ebreak_word);
  end
endtask

// walks the program and queues the expected retire records
task automatic run_model();
  logic [rv_pkg::xlen-1:0] pc;
  logic [rv_pkg::xlen-1:0] a;
  logic [rv_pkg::xlen-1:0] b;
  logic [rv_pkg::xlen-1:0] val;
  logic [rv_pkg::xlen-1:0] jimm;
  logic [31:0]             w;
  logic [4:0]              rd;
  bit                      legal;
  bit                      jump;
  bit                      done;
  int                      steps;
  exp_pc.delete();
  exp_rd.delete();
  exp_data.delete();
  pc    = rv_pkg::pc_rst;
  done  = 1'b0;
  steps = 0;
  while (!done && steps < 1000) begin
    w     = prog[(pc - rv_pkg::pc_rst) >> 2];
    rd    = w[11:7];
    a     = (w[19:15] == 5'd0) ? '0 : model_regs[w[19:15]];
    b     = (w[24:20] == 5'd0) ? '0 : model_regs[w[24:20]];
    legal = 1'b1;
    jump  = 1'b0;
    jimm  = '0;
    val   = '0;
    case (w[6:0])
      rv_pkg::op_lui:   val = {{32{w[31]}}, w[31:12], 12'b0};
      rv_pkg::op_auipc: val = pc + {{32{w[31]}}, w[31:12], 12'b0};
      rv_pkg::op_op_imm: begin
        if (w[14:12] == 3'b000) begin
          val = a + {{52{w[31]}}, w[31:20]};
        end else begin
          legal = 1'b0;
        end
      end
      rv_pkg::op_op: begin
        if (w[14:12] == 3'b000 && w[31:25] == 7'b0000000) begin
          val = a + b;
        end else if (w[14:12] == 3'b000 && w[31:25] == 7'b0100000) begin
          val = a - b;
        end else begin
          legal = 1'b0;
        end
      end
      rv_pkg::op_jal: begin
        val  = pc + 64'd4;
        jimm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        jump = 1'b1;
      end
      default: legal = 1'b0;
    endcase
    if (w == rv_pkg::ebreak_word) begin
      exp_final = rv_pkg::st_halted;
      done      = 1'b1;
    end else if (!legal) begin
      exp_final = rv_pkg::st_trapped;
      done      = 1'b1;
    end else begin
      exp_pc.push_back(pc);
      exp_rd.push_back(rd);
      exp_data.push_back(val);
      if (rd != 5'd0) begin
        model_regs[rd] = val;
      end
      pc = jump ? pc + jimm : pc + 64'd4;
    end
    steps++;
  end
  // pc holds at the stopping word
  exp_stop_pc = pc;
endtask

`endif

// File: tb/tb_rv_core.sv
// **********************************************************************
// random programs against the reference model, reset, load, start each
// inputs change and outputs are sampled on the falling clock edge
// **********************************************************************
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

  localparam int clk_period   = 4;
  localparam int num_programs = 12;
  localparam int max_exec     = 24;
  localparam int max_words    = 4 * max_exec + 1;
  // reset, load, gap, start, run and drain cycles of the longest program
  localparam int prog_cycles  = 5 + max_words + 2 + max_exec + 1 + 6;
  localparam int timeout_ns   = num_programs * prog_cycles * clk_period + 400;

  logic                               clk;
  logic                               reset;
  logic                               load_en;
  logic [rv_pkg::imem_addr_width-1:0] load_addr;
  logic [rv_pkg::inst_width-1:0]      load_data;
  logic                               start;
  logic                               retire;
  logic [rv_pkg::xlen-1:0]            retire_pc;
  logic                               wb_en;
  logic [rv_pkg::reg_id_width-1:0]    wb_rd;
  logic [rv_pkg::xlen-1:0]            wb_data;
  rv_pkg::run_state_t                 state;
  logic                               halted;
  logic                               trapped;

  `include "rv_iss.svh"

  rv_core_top dut (
    .clk       (clk),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .start     (start),
    .retire    (retire),
    .retire_pc (retire_pc),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .state     (state),
    .halted    (halted),
    .trapped   (trapped)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // watchdog
  initial begin
    #(timeout_ns);
    $display("timeout: core did not finish the programs within %0d ns", timeout_ns);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_retire(
    input logic [rv_pkg::xlen-1:0]         pc_got,
    input logic [rv_pkg::xlen-1:0]         pc_exp,
    input logic [rv_pkg::reg_id_width-1:0] rd_got,
    input logic [rv_pkg::reg_id_width-1:0] rd_exp,
    input logic [rv_pkg::xlen-1:0]         data_got,
    input logic [rv_pkg::xlen-1:0]         data_exp
  );
    if (pc_got !== pc_exp) begin
      fail_run($sformatf("mismatch at %0t: retire_pc got %h expected %h",
                         $time, pc_got, pc_exp));
    end
    if (rd_got !== rd_exp) begin
      fail_run($sformatf("mismatch at %0t: wb_rd got %0d expected %0d",
                         $time, rd_got, rd_exp));
    end
    if (data_got !== data_exp) begin
      fail_run($sformatf("mismatch at %0t: wb_data got %h expected %h",
                         $time, data_got, data_exp));
    end
  endtask

  task automatic check_state(input rv_pkg::run_state_t got, input rv_pkg::run_state_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: state got %s expected %s",
                         $time, got.name(), exp.name()));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_pc(input logic [rv_pkg::xlen-1:0] got,
                          input logic [rv_pkg::xlen-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: retire_pc got %h expected %h", $time, got, exp));
    end
  endtask

  // one program, reset, load, start, compare until stop
  task automatic run_program(input int n_exec, input bit end_illegal);
    logic [rv_pkg::xlen-1:0]         pc_e;
    logic [rv_pkg::reg_id_width-1:0] rd_e;
    logic [rv_pkg::xlen-1:0]         data_e;
    int                              i;
    build_program(n_exec, end_illegal);
    run_model();
    reset   = 1'b1;
    load_en = 1'b0;
    start   = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    check_state(state, rv_pkg::st_idle);
    check_flag("halted", halted, 1'b0);
    check_flag("trapped", trapped, 1'b0);
    check_flag("retire", retire, 1'b0);
    check_pc(retire_pc, rv_pkg::pc_rst);
    // word 0 first so the fetch register picks it up before start
    for (i = 0; i < prog.size(); i++) begin
      load_en   = 1'b1;
      load_addr = rv_pkg::imem_addr_width'(i);
      load_data = prog[i];
      @(negedge clk);
      check_flag("retire", retire, 1'b0);
      check_state(state, rv_pkg::st_idle);
    end
    load_en = 1'b0;
    @(negedge clk);
    check_flag("retire", retire, 1'b0);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_state(state, rv_pkg::st_run);
    // in run, retire must be up exactly while records remain
    while (state == rv_pkg::st_run) begin
      check_flag("retire", retire, exp_pc.size() != 0);
      if (retire) begin
        check_flag("wb_en", wb_en, 1'b1);
        pc_e   = exp_pc.pop_front();
        rd_e   = exp_rd.pop_front();
        data_e = exp_data.pop_front();
        check_retire(retire_pc, pc_e, wb_rd, rd_e, wb_data, data_e);
      end
      @(negedge clk);
    end
    if (exp_pc.size() != 0) begin
      fail_run($sformatf("core stopped with %0d expected retires left", exp_pc.size()));
    end
    // stop state is sticky with no more retires
    repeat (4) begin
      check_state(state, exp_final);
      check_flag("halted", halted, exp_final == rv_pkg::st_halted);
      check_flag("trapped", trapped, exp_final == rv_pkg::st_trapped);
      check_flag("retire", retire, 1'b0);
      check_flag("wb_en", wb_en, 1'b0);
      check_pc(retire_pc, exp_stop_pc);
      @(negedge clk);
    end
  endtask

  initial begin
    int p;
    int n;
    rng_state = 32'h567a;
    reset     = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    start     = 1'b0;
    for (p = 0; p < 32; p++) begin
      reg_written[p] = (p == 0);
      model_regs[p]  = '0;
    end
    for (p = 0; p < num_programs; p++) begin
      // first program is a bare ebreak
      if (p == 0) begin
        n = 0;
      end else begin
        n = 4 + (rand_word() % (max_exec - 3));
      end
      run_program(n, (p % 3) == 2);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+tb
hdl/rv_pkg.sv
hdl/inst_mem.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/pc_counter.sv
hdl/run_control.sv
hdl/rv_core_top.sv
tb/tb_rv_core.sv
